/* hdl/cpu_pkg.sv */
package cpu_pkg;

   localparam int CODE_AW = 8;   // 256 byte program space
   localparam int DATA_W  = 8;
   localparam int REG_AW  = 3;   // R0..R7

   // kept instruction set, unknown bytes fall to OP_ILLEGAL
   typedef enum logic [4:0] {
      OP_MOV_A_IMM,
      OP_MOV_R_IMM,
      OP_MOV_A_REG,
      OP_MOV_R_A,
      OP_ADD_A_IMM,
      OP_ADD_A_REG,
      OP_ADDC_A_IMM,
      OP_ADDC_A_REG,
      OP_SUBB_A_IMM,
      OP_SUBB_A_REG,
      OP_INC_A,
      OP_DEC_A,
      OP_INC_R,
      OP_DEC_R,
      OP_ANL_A_IMM,
      OP_ORL_A_IMM,
      OP_XRL_A_IMM,
      OP_CLR_A,
      OP_CPL_A,
      OP_CLR_C,
      OP_SETB_C,
      OP_SJMP,
      OP_JZ,
      OP_JNZ,
      OP_JC,
      OP_JNC,
      OP_DJNZ,
      OP_ILLEGAL
   } opcode_e;

   typedef enum logic [1:0] {
      ST_FETCH,   // opcode byte
      ST_OPND,    // immediate or offset byte
      ST_EXEC
   } seq_state_e;

   typedef struct packed {
      opcode_e             opcode;
      logic [REG_AW-1:0]   rn;
      logic                has_opnd;   // second byte follows
   } decode_t;

   typedef struct packed {
      logic                en;
      logic [REG_AW-1:0]   idx;
      logic [DATA_W-1:0]   data;
   } reg_wr_t;

   typedef struct packed {
      logic                valid;
      logic [CODE_AW-1:0]  pc;
      logic [DATA_W-1:0]   acc;
      logic                carry;
      reg_wr_t             wr;
   } commit_t;

endpackage

/* hdl/instr_decode.sv */
`timescale 1ns/100ps

module instr_decode import cpu_pkg::*; (
   input  logic [DATA_W-1:0]  i_opbyte,
   output decode_t            o_dec
);

opcode_e op;

////////////////////////////////////////////////////////////////////////////
// opcode map, Rn groups share the upper five bits

always_comb begin
   casez (i_opbyte)
      8'h74:         op = OP_MOV_A_IMM;
      8'b0111_1???:  op = OP_MOV_R_IMM;    // 78..7f
      8'b1110_1???:  op = OP_MOV_A_REG;    // e8..ef
      8'b1111_1???:  op = OP_MOV_R_A;      // f8..ff
      8'h24:         op = OP_ADD_A_IMM;
      8'b0010_1???:  op = OP_ADD_A_REG;
      8'h34:         op = OP_ADDC_A_IMM;
      8'b0011_1???:  op = OP_ADDC_A_REG;
      8'h94:         op = OP_SUBB_A_IMM;
      8'b1001_1???:  op = OP_SUBB_A_REG;
      8'h04:         op = OP_INC_A;
      8'h14:         op = OP_DEC_A;
      8'b0000_1???:  op = OP_INC_R;
      8'b0001_1???:  op = OP_DEC_R;
      8'h54:         op = OP_ANL_A_IMM;
      8'h44:         op = OP_ORL_A_IMM;
      8'h64:         op = OP_XRL_A_IMM;
      8'he4:         op = OP_CLR_A;
      8'hf4:         op = OP_CPL_A;
      8'hc3:         op = OP_CLR_C;
      8'hd3:         op = OP_SETB_C;
      8'h80:         op = OP_SJMP;
      8'h60:         op = OP_JZ;
      8'h70:         op = OP_JNZ;
      8'h40:         op = OP_JC;
      8'h50:         op = OP_JNC;
      8'b1101_1???:  op = OP_DJNZ;         // d8..df
      default:       op = OP_ILLEGAL;      // runs as a one byte no-op
   endcase
end

always_comb begin
   o_dec.opcode = op;
   o_dec.rn     = i_opbyte[REG_AW-1:0];
   case (op)
      OP_MOV_A_IMM,
      OP_MOV_R_IMM,
      OP_ADD_A_IMM,
      OP_ADDC_A_IMM,
      OP_SUBB_A_IMM,
      OP_ANL_A_IMM,
      OP_ORL_A_IMM,
      OP_XRL_A_IMM:  o_dec.has_opnd = 1'b1;   // immediate
      OP_SJMP,
      OP_JZ,
      OP_JNZ,
      OP_JC,
      OP_JNC,
      OP_DJNZ:       o_dec.has_opnd = 1'b1;   // relative offset
      default:       o_dec.has_opnd = 1'b0;
   endcase
end

endmodule

/* hdl/code_fetch.sv */
`timescale 1ns/100ps

module code_fetch import cpu_pkg::*; #(
   parameter int CODE_AW = cpu_pkg::CODE_AW
) (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_code_ack,
   input  logic [DATA_W-1:0]  i_code_data,
   input  decode_t            i_dec,
   input  logic               i_br_taken,
   input  logic [CODE_AW-1:0] i_br_target,
   output logic               o_code_req,
   output logic [CODE_AW-1:0] o_code_addr,
   output logic [DATA_W-1:0]  o_opbyte,
   output logic [DATA_W-1:0]  o_operand,
   output logic [CODE_AW-1:0] o_pc,
   output logic               o_exec
);

seq_state_e          state;
seq_state_e          state_next;
logic                req;
logic                ack_wait;      // byte taken, ack not yet seen low
logic                ack_low_seen;
logic                capture;
logic [CODE_AW-1:0]  pc;
logic [CODE_AW-1:0]  instr_pc;      // address of the opcode byte
logic [DATA_W-1:0]   opbyte_q;
logic [DATA_W-1:0]   operand_q;

////////////////////////////////////////////////////////////////////////////
// four-phase handshake

assign ack_low_seen = !ack_wait || !i_code_ack;
assign capture      = req && i_code_ack;

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      req      <= 1'b0;
      ack_wait <= 1'b0;
   end else begin
      if (capture)
         req <= 1'b0;
      else if (!req && ack_low_seen)
         req <= 1'b1;   // also fires on the exec edge for the next opcode
      if (capture)
         ack_wait <= 1'b1;
      else if (!i_code_ack)
         ack_wait <= 1'b0;
   end
end

////////////////////////////////////////////////////////////////////////////
// sequencer

always_comb begin
   state_next = state;
   case (state)
      ST_FETCH: begin
         if (capture)
            state_next = i_dec.has_opnd ? ST_OPND : ST_EXEC;
      end
      ST_OPND: begin
         if (capture)
            state_next = ST_EXEC;
      end
      default: state_next = ST_FETCH;
   endcase
end

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst)
      state <= ST_FETCH;
   else
      state <= state_next;
end

// pc steps per byte, branch target replaces it on exec
always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst)
      pc <= '0;
   else if (capture)
      pc <= pc + CODE_AW'(1);
   else if (o_exec && i_br_taken)
      pc <= i_br_target;
end

always_ff @(posedge i_clk) begin
   if (capture && state == ST_FETCH) begin
      opbyte_q <= i_code_data;
      instr_pc <= pc;
   end
   if (capture && state == ST_OPND)
      operand_q <= i_code_data;
end

// decode sees the byte straight off the bus while it is captured
assign o_opbyte    = (state == ST_FETCH) ? i_code_data : opbyte_q;
assign o_operand   = operand_q;
assign o_pc        = instr_pc;
assign o_exec      = (state == ST_EXEC);
assign o_code_req  = req;
assign o_code_addr = pc;

endmodule

/* hdl/alu_execute.sv */
`timescale 1ns/100ps

module alu_execute import cpu_pkg::*; #(
   parameter int CODE_AW = cpu_pkg::CODE_AW
) (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_exec,
   input  decode_t            i_dec,
   input  logic [DATA_W-1:0]  i_operand,
   input  logic [CODE_AW-1:0] i_pc,
   input  logic [DATA_W-1:0]  i_reg_rdata,
   output logic [DATA_W-1:0]  o_acc,
   output logic               o_carry,
   output reg_wr_t            o_reg_wr,
   output logic               o_br_taken,
   output logic [CODE_AW-1:0] o_br_target
);

logic [DATA_W-1:0]         acc;
logic                      carry;
logic [DATA_W-1:0]         acc_next;
logic                      carry_next;
logic [DATA_W-1:0]         src;
logic                      cin;
logic [DATA_W:0]           add_res;    // bit 8 is carry out
logic [DATA_W:0]           sub_res;    // bit 8 is borrow
logic [DATA_W-1:0]         reg_dec;
logic [CODE_AW+DATA_W-1:0] off_ext;

////////////////////////////////////////////////////////////////////////////
// ALU

assign src = (i_dec.opcode inside {OP_ADD_A_REG, OP_ADDC_A_REG, OP_SUBB_A_REG}) ?
             i_reg_rdata : i_operand;
assign cin = carry && (i_dec.opcode inside {OP_ADDC_A_IMM, OP_ADDC_A_REG});

assign add_res = {1'b0, acc} + {1'b0, src} + {{DATA_W{1'b0}}, cin};
assign sub_res = {1'b0, acc} - {1'b0, src} - {{DATA_W{1'b0}}, carry};
assign reg_dec = i_reg_rdata - DATA_W'(1);

always_comb begin
   acc_next   = acc;
   carry_next = carry;
   case (i_dec.opcode)
      OP_MOV_A_IMM:  acc_next = i_operand;
      OP_MOV_A_REG:  acc_next = i_reg_rdata;
      OP_ADD_A_IMM,
      OP_ADD_A_REG,
      OP_ADDC_A_IMM,
      OP_ADDC_A_REG: {carry_next, acc_next} = add_res;
      OP_SUBB_A_IMM,
      OP_SUBB_A_REG: {carry_next, acc_next} = sub_res;
      OP_INC_A:      acc_next = acc + DATA_W'(1);   // carry untouched
      OP_DEC_A:      acc_next = acc - DATA_W'(1);
      OP_ANL_A_IMM:  acc_next = acc & i_operand;
      OP_ORL_A_IMM:  acc_next = acc | i_operand;
      OP_XRL_A_IMM:  acc_next = acc ^ i_operand;
      OP_CLR_A:      acc_next = '0;
      OP_CPL_A:      acc_next = ~acc;
      OP_CLR_C:      carry_next = 1'b0;
      OP_SETB_C:     carry_next = 1'b1;
      default:       ;
   endcase
end

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      acc   <= '0;
      carry <= 1'b0;
   end else if (i_exec) begin
      acc   <= acc_next;
      carry <= carry_next;
   end
end

// register write-back, qualified by exec downstream
always_comb begin
   o_reg_wr.en   = 1'b1;
   o_reg_wr.idx  = i_dec.rn;
   o_reg_wr.data = reg_dec;
   case (i_dec.opcode)
      OP_MOV_R_IMM:  o_reg_wr.data = i_operand;
      OP_MOV_R_A:    o_reg_wr.data = acc;
      OP_INC_R:      o_reg_wr.data = i_reg_rdata + DATA_W'(1);
      OP_DEC_R,
      OP_DJNZ:       o_reg_wr.data = reg_dec;
      default:       o_reg_wr.en   = 1'b0;
   endcase
end

////////////////////////////////////////////////////////////////////////////
// branches

always_comb begin
   case (i_dec.opcode)
      OP_SJMP:  o_br_taken = 1'b1;
      OP_JZ:    o_br_taken = (acc == '0);
      OP_JNZ:   o_br_taken = (acc != '0);
      OP_JC:    o_br_taken = carry;
      OP_JNC:   o_br_taken = !carry;
      OP_DJNZ:  o_br_taken = (reg_dec != '0);
      default:  o_br_taken = 1'b0;
   endcase
end

// all branches are two bytes, offset is from the next instruction
assign off_ext     = {{CODE_AW{i_operand[DATA_W-1]}}, i_operand};
assign o_br_target = i_pc + CODE_AW'(2) + off_ext[CODE_AW-1:0];

assign o_acc   = acc;
assign o_carry = carry;

endmodule

/* hdl/reg_result.sv */
`timescale 1ns/100ps

module reg_result import cpu_pkg::*; #(
   parameter int CODE_AW = cpu_pkg::CODE_AW
) (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_exec,
   input  decode_t            i_dec,
   input  logic [CODE_AW-1:0] i_pc,
   input  logic [DATA_W-1:0]  i_acc,
   input  logic               i_carry,
   input  reg_wr_t            i_reg_wr,
   output logic [DATA_W-1:0]  o_reg_rdata,
   output commit_t            o_commit
);

logic [DATA_W-1:0]   regs [2**REG_AW];
logic                commit_vld;
logic [CODE_AW-1:0]  commit_pc;
reg_wr_t             commit_wr;

////////////////////////////////////////////////////////////////////////////
// R0..R7

assign o_reg_rdata = regs[i_dec.rn];

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst) begin
      for (int i = 0; i < 2**REG_AW; i++)
         regs[i] <= '0;
   end else if (i_exec && i_reg_wr.en) begin
      regs[i_reg_wr.idx] <= i_reg_wr.data;
   end
end

////////////////////////////////////////////////////////////////////////////
// commit record, one cycle after exec

always_ff @(posedge i_clk or negedge i_nrst) begin
   if (!i_nrst)
      commit_vld <= 1'b0;
   else
      commit_vld <= i_exec;   // single cycle pulse
end

always_ff @(posedge i_clk) begin
   if (i_exec) begin
      commit_pc <= i_pc;
      commit_wr <= i_reg_wr;
   end
end

// acc and carry were loaded on the same exec edge
always_comb begin
   o_commit.valid = commit_vld;
   o_commit.pc    = commit_pc;
   o_commit.acc   = i_acc;
   o_commit.carry = i_carry;
   o_commit.wr    = commit_wr;
end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; #(
   parameter int CODE_AW = cpu_pkg::CODE_AW
) (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_code_ack,
   input  logic [DATA_W-1:0]  i_code_data,
   output logic               o_code_req,
   output logic [CODE_AW-1:0] o_code_addr,
   output commit_t            o_commit
);

decode_t             dec;
logic [DATA_W-1:0]   opbyte;
logic [DATA_W-1:0]   operand;
logic [CODE_AW-1:0]  pc;
logic                exec;
logic                br_taken;
logic [CODE_AW-1:0]  br_target;
logic [DATA_W-1:0]   acc;
logic                carry;
reg_wr_t             reg_wr;
logic [DATA_W-1:0]   reg_rdata;

code_fetch #(.CODE_AW(CODE_AW)) code_fetch_i (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_code_ack    (i_code_ack),
   .i_code_data   (i_code_data),
   .i_dec         (dec),
   .i_br_taken    (br_taken),
   .i_br_target   (br_target),
   .o_code_req    (o_code_req),
   .o_code_addr   (o_code_addr),
   .o_opbyte      (opbyte),
   .o_operand     (operand),
   .o_pc          (pc),
   .o_exec        (exec)
);

instr_decode instr_decode_i (
   .i_opbyte      (opbyte),
   .o_dec         (dec)
);

alu_execute #(.CODE_AW(CODE_AW)) alu_execute_i (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_exec        (exec),
   .i_dec         (dec),
   .i_operand     (operand),
   .i_pc          (pc),
   .i_reg_rdata   (reg_rdata),
   .o_acc         (acc),
   .o_carry       (carry),
   .o_reg_wr      (reg_wr),
   .o_br_taken    (br_taken),
   .o_br_target   (br_target)
);

reg_result #(.CODE_AW(CODE_AW)) reg_result_i (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_exec        (exec),
   .i_dec         (dec),
   .i_pc          (pc),
   .i_acc         (acc),
   .i_carry       (carry),
   .i_reg_wr      (reg_wr),
   .o_reg_rdata   (reg_rdata),
   .o_commit      (o_commit)
);

endmodule

/* tb/tb_cpu_assert.sv */
`timescale 1ns/100ps

module cpu_fetch_assert import cpu_pkg::*; #(
   parameter int CODE_AW = cpu_pkg::CODE_AW
) (
   input logic               i_clk,
   input logic               i_nrst,
   input logic               i_code_req,
   input logic               i_code_ack,
   input logic [CODE_AW-1:0] i_code_addr,
   input commit_t            i_commit
);

// next request only once the previous ack is low
req_rise_after_ack_low: assert property (@(posedge i_clk) disable iff (!i_nrst)
   $rose(i_code_req) |-> !$past(i_code_ack))
   else $error("code req rose while ack was still high");

addr_stable_during_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
   i_code_req && $past(i_code_req) |-> $stable(i_code_addr))
   else $error("code address changed while req was high");

req_held_until_ack: assert property (@(posedge i_clk) disable iff (!i_nrst)
   i_code_req && !i_code_ack |=> i_code_req)
   else $error("code req dropped before ack arrived");

commit_single_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
   i_commit.valid |=> !i_commit.valid)
   else $error("commit valid high in two consecutive cycles");

endmodule

bind cpu_top cpu_fetch_assert #(.CODE_AW(CODE_AW)) cpu_fetch_assert_i (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_code_req    (o_code_req),
   .i_code_ack    (i_code_ack),
   .i_code_addr   (o_code_addr),
   .i_commit      (o_commit)
);

/* tb/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*; ();

localparam int N_INSTR        = 400;
localparam int MAX_ACK_DELAY  = 3;
localparam int RESET_CYCLES   = 5;
localparam int TIMEOUT_CYCLES = N_INSTR * 2 * (3 + MAX_ACK_DELAY + 2) + RESET_CYCLES;
localparam logic [15:0] LFSR_SEED = 16'd36;

// opcode pool, Rn groups stored with low bits zero
localparam logic [31:0][7:0] OP_TABLE = {
   8'h78, 8'he8, 8'hf8, 8'h28, 8'h38, 8'h98, 8'h08, 8'h18,
   8'hd8, 8'h74, 8'h24, 8'h34, 8'h94, 8'h04, 8'h14, 8'h54,
   8'h44, 8'h64, 8'he4, 8'hf4, 8'hc3, 8'hd3, 8'h80, 8'h60,
   8'h70, 8'h40, 8'h50, 8'ha5, 8'hd8, 8'h94, 8'h34, 8'h70};

logic                i_clk;
logic                i_nrst;
logic                i_code_ack;
logic [DATA_W-1:0]   i_code_data;
logic                o_code_req;
logic [CODE_AW-1:0]  o_code_addr;
commit_t             o_commit;

logic [7:0]   code_mem [256];
logic [15:0]  lfsr;
logic [1:0]   delay_left;
logic [3:0]   delay_seen = '0;
int           cycle_cnt = 0;
int           commit_cnt = 0;
int           taken_cnt = 0;
int           not_taken_cnt = 0;
int           reset_errs = 0;
int           alu_errs = 0;
int           wr_errs = 0;
int           flow_errs = 0;
int           hs_errs = 0;
int           total_errs;

// instruction-set model state and the expected commit
logic [7:0]   m_pc;
logic [7:0]   m_acc;
logic         m_carry;
logic [7:0]   m_regs [8];
logic [7:0]   exp_pc;
logic [7:0]   exp_acc;
logic         exp_carry;
logic         exp_wr_en;
logic [2:0]   exp_wr_idx;
logic [7:0]   exp_wr_data;

cpu_top #(.CODE_AW(CODE_AW)) cpu_top_i (
   .i_clk         (i_clk),
   .i_nrst        (i_nrst),
   .i_code_ack    (i_code_ack),
   .i_code_data   (i_code_data),
   .o_code_req    (o_code_req),
   .o_code_addr   (o_code_addr),
   .o_commit      (o_commit)
);

initial begin
   i_clk = 1'b0;
   forever #4 i_clk = ~i_clk;   // 8 ns period
end

////////////////////////////////////////////////////////////////////////////
// random source and program image

function automatic logic [15:0] lfsr_step(input logic [15:0] s);
   return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// one lfsr step per bit taken
function automatic logic [7:0] rand_bits(input int n);
   logic [7:0] v;
   v = '0;
   for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[6:0], lfsr[0]};
   end
   return v;
endfunction

function automatic logic rn_group(input logic [7:0] op);
   return op[7:3] inside {5'b01111, 5'b11101, 5'b11111, 5'b00101, 5'b00111,
                          5'b10011, 5'b00001, 5'b00011, 5'b11011};
endfunction

function automatic logic two_byte(input logic [7:0] op);
   return (op inside {8'h74, 8'h24, 8'h34, 8'h94, 8'h54, 8'h44, 8'h64,
                      8'h80, 8'h60, 8'h70, 8'h40, 8'h50})
          || op[7:3] == 5'b01111 || op[7:3] == 5'b11011;
endfunction

task automatic fill_code();
   logic [7:0] op;
   logic       want_opnd;
   want_opnd = 1'b0;
   for (int a = 0; a < 256; a++) begin
      if (want_opnd) begin
         code_mem[a] = rand_bits(8);   // immediate or branch offset
         want_opnd   = 1'b0;
      end else begin
         op = OP_TABLE[5'(rand_bits(5))];
         if (rn_group(op))
            op = op | rand_bits(3);
         code_mem[a] = op;
         want_opnd   = two_byte(op);
      end
   end
endtask

////////////////////////////////////////////////////////////////////////////
// code memory, ack after a random delay, drops ack once req is low

always @(posedge i_clk) begin
   #1;
   if (i_nrst) begin
      if (i_code_ack) begin
         if (!o_code_req) begin
            i_code_ack = 1'b0;
            delay_left = 2'(rand_bits(2));
            delay_seen[delay_left] = 1'b1;
         end
      end else if (o_code_req) begin
         if (delay_left == 2'd0) begin
            i_code_ack  = 1'b1;
            i_code_data = code_mem[o_code_addr];
         end else begin
            delay_left = delay_left - 2'd1;
         end
      end
   end
end

// reference model, one instruction per call
task automatic model_step();
   logic [7:0] op;
   logic [7:0] opnd;
   logic [2:0] rn;
   logic [7:0] rval;
   logic       is_br;
   logic       take;
   op          = code_mem[m_pc];
   opnd        = code_mem[m_pc + 8'd1];
   rn          = op[2:0];
   rval        = m_regs[rn];
   is_br       = 1'b0;
   take        = 1'b0;
   exp_pc      = m_pc;
   exp_wr_en   = 1'b0;
   exp_wr_idx  = rn;
   exp_wr_data = 8'd0;
   case (op)
      8'h74: m_acc = opnd;
      8'h24: {m_carry, m_acc} = {1'b0, m_acc} + {1'b0, opnd};
      8'h34: {m_carry, m_acc} = {1'b0, m_acc} + {1'b0, opnd} + {8'd0, m_carry};
      8'h94: {m_carry, m_acc} = {1'b0, m_acc} - {1'b0, opnd} - {8'd0, m_carry};
      8'h04: m_acc = m_acc + 8'd1;
      8'h14: m_acc = m_acc - 8'd1;
      8'h54: m_acc = m_acc & opnd;
      8'h44: m_acc = m_acc | opnd;
      8'h64: m_acc = m_acc ^ opnd;
      8'he4: m_acc = 8'd0;
      8'hf4: m_acc = ~m_acc;
      8'hc3: m_carry = 1'b0;
      8'hd3: m_carry = 1'b1;
      8'h80: begin is_br = 1'b1; take = 1'b1; end
      8'h60: begin is_br = 1'b1; take = (m_acc == 8'd0); end
      8'h70: begin is_br = 1'b1; take = (m_acc != 8'd0); end
      8'h40: begin is_br = 1'b1; take = m_carry; end
      8'h50: begin is_br = 1'b1; take = !m_carry; end
      default: begin
         case (op[7:3])
            5'b01111: begin exp_wr_en = 1'b1; exp_wr_data = opnd; end
            5'b11101: m_acc = rval;
            5'b11111: begin exp_wr_en = 1'b1; exp_wr_data = m_acc; end
            5'b00101: {m_carry, m_acc} = {1'b0, m_acc} + {1'b0, rval};
            5'b00111: {m_carry, m_acc} = {1'b0, m_acc} + {1'b0, rval} + {8'd0, m_carry};
            5'b10011: {m_carry, m_acc} = {1'b0, m_acc} - {1'b0, rval} - {8'd0, m_carry};
            5'b00001: begin exp_wr_en = 1'b1; exp_wr_data = rval + 8'd1; end
            5'b00011: begin exp_wr_en = 1'b1; exp_wr_data = rval - 8'd1; end
            5'b11011: begin
               exp_wr_en   = 1'b1;
               exp_wr_data = rval - 8'd1;
               is_br       = 1'b1;
               take        = (exp_wr_data != 8'd0);
            end
            default: ;   // illegal byte, no-op
         endcase
      end
   endcase
   if (exp_wr_en)
      m_regs[rn] = exp_wr_data;
   exp_acc   = m_acc;
   exp_carry = m_carry;
   if (is_br && take)
      taken_cnt++;
   else if (is_br)
      not_taken_cnt++;
   // 8-bit pc, so the wrap also sign-extends the offset
   m_pc = take ? (m_pc + 8'd2 + opnd) : (m_pc + (two_byte(op) ? 8'd2 : 8'd1));
endtask

////////////////////////////////////////////////////////////////////////////
// commit checks

always @(negedge i_clk) begin
   if (i_nrst && o_commit.valid && commit_cnt < N_INSTR) begin
      model_step();
      assert (o_commit.pc == exp_pc) else begin
         $display("ERROR control_flow: commit %0d pc expected %h actual %h",
                  commit_cnt, exp_pc, o_commit.pc);
         flow_errs++;
      end
      assert (o_commit.acc == exp_acc && o_commit.carry == exp_carry) else begin
         $display("ERROR alu: commit %0d acc/carry expected %h/%b actual %h/%b",
                  commit_cnt, exp_acc, exp_carry, o_commit.acc, o_commit.carry);
         alu_errs++;
      end
      assert (o_commit.wr.en == exp_wr_en) else begin
         $display("ERROR reg_write: commit %0d write enable expected %b actual %b",
                  commit_cnt, exp_wr_en, o_commit.wr.en);
         wr_errs++;
      end
      if (exp_wr_en) begin
         assert (o_commit.wr.idx == exp_wr_idx && o_commit.wr.data == exp_wr_data) else begin
            $display("ERROR reg_write: commit %0d R%0d=%h expected, actual R%0d=%h",
                     commit_cnt, exp_wr_idx, exp_wr_data, o_commit.wr.idx, o_commit.wr.data);
            wr_errs++;
         end
      end
      commit_cnt++;
   end
end

always @(posedge i_clk) begin
   cycle_cnt++;
   if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: %0d of %0d instructions committed after %0d cycles",
               commit_cnt, N_INSTR, cycle_cnt);
      $display("Errors found");
      $finish;
   end
end

initial begin
   i_nrst      = 1'b0;
   i_code_ack  = 1'b0;
   i_code_data = '0;
   lfsr        = LFSR_SEED;
   fill_code();
   delay_left  = 2'(rand_bits(2));
   delay_seen[delay_left] = 1'b1;
   m_pc    = 8'd0;
   m_acc   = 8'd0;
   m_carry = 1'b0;
   for (int i = 0; i < 8; i++)
      m_regs[i] = 8'd0;

   repeat (RESET_CYCLES) @(posedge i_clk);
   #1;
   assert (!o_code_req && !o_commit.valid) else begin
      $display("ERROR reset: req/valid expected 0/0 actual %b/%b",
               o_code_req, o_commit.valid);
      reset_errs++;
   end
   i_nrst = 1'b1;
   do begin
      @(posedge i_clk);
      #1;
   end while (!o_code_req);
   assert (o_code_addr == '0) else begin
      $display("ERROR reset: first fetch address expected %h actual %h", 8'h00, o_code_addr);
      reset_errs++;
   end
   $display("test reset: %0d errors", reset_errs);

   while (commit_cnt < N_INSTR)
      @(posedge i_clk);
   $display("test alu: %0d commits, %0d errors", commit_cnt, alu_errs);
   $display("test reg_write: %0d errors", wr_errs);
   $display("test control_flow: %0d taken, %0d not taken, %0d errors",
            taken_cnt, not_taken_cnt, flow_errs);
   assert (delay_seen == 4'hf) else begin
      $display("ack delays 0 to 3 were not all used, seen mask %b", delay_seen);
      hs_errs++;
   end
   $display("test handshake: %0d cycles, %0d errors", cycle_cnt, hs_errs);

   total_errs = reset_errs + alu_errs + wr_errs + flow_errs + hs_errs;
   $display("totals: 5 tests, %0d commits, %0d errors", commit_cnt, total_errs);
   if (total_errs == 0)
      $display("No errors");
   else
      $display("Errors found");
   $finish;
end

endmodule

/* compile.f */
hdl/cpu_pkg.sv
hdl/instr_decode.sv
hdl/code_fetch.sv
hdl/alu_execute.sv
hdl/reg_result.sv
hdl/cpu_top.sv
tb/tb_cpu_assert.sv
tb/tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
RTL_TOP   ?= cpu_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  := Errors found
PASS_MSG  := No errors

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
